// ==== verilog/mem_map_pkg.sv ====
package mem_map_pkg;

    // Bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // GPIO block has one address per pin in each bank
    localparam int unsigned GPIO_PINS = 10;

    // Address map
    localparam logic [ADDR_W-1:0] RESERVED_LIMIT_LO = 32'h0000_0100;
    localparam logic [ADDR_W-1:0] GPIO_DIR_BASE     = 32'h0000_0101;
    localparam logic [ADDR_W-1:0] GPIO_VAL_BASE     = 32'h0000_010B;
    localparam logic [ADDR_W-1:0] TIMER_ADDR        = 32'h0000_0115;
    localparam logic [ADDR_W-1:0] SRAM_BASE         = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] SRAM_LIMIT        = 32'h0000_1FFF;
    localparam logic [ADDR_W-1:0] STORAGE_BASE      = 32'h0000_2000;

    // Standard single-bit flash read opcode
    localparam logic [7:0] SPI_READ_CMD = 8'h03;

    // Router sequencing
    typedef enum logic [2:0] {
        idle,
        gpio_access,
        timer_access,
        sram_wait,
        sram_done,
        storage_wait,
        error_resp
    } route_state_t;

endpackage

// ==== verilog/mem_router.sv ====
`timescale 1ns/1ps

module mem_router import mem_map_pkg::*; #(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic                        clk,
    input  logic                        rst,

    // Core bus
    input  logic                        req_i,
    input  logic [ADDR_W-1:0]           addr_i,
    input  logic                        we_i,
    input  logic [DATA_W/8-1:0]         be_i,
    input  logic [DATA_W-1:0]           wdata_i,
    output logic                        ready_o,
    output logic                        rvalid_o,
    output logic                        err_o,
    output logic [DATA_W-1:0]           rdata_o,

    // GPIO registers
    output logic                        gpio_sel_o,
    output logic                        gpio_we_o,
    output logic [3:0]                  gpio_idx_o,
    output logic                        gpio_is_dir_o,
    output logic [DATA_W-1:0]           gpio_wdata_o,
    input  logic [DATA_W-1:0]           gpio_rdata_i,
    input  logic                        gpio_fault_i,

    // Timer
    output logic                        timer_load_o,
    output logic [DATA_W-1:0]           timer_load_val_o,
    input  logic                        timer_running_i,

    // Scratch RAM
    output logic                        ram_en_o,
    output logic                        ram_we_o,
    output logic [DATA_W/8-1:0]         ram_be_o,
    output logic [$clog2(SRAM_WORDS)-1:0] ram_word_addr_o,
    output logic [DATA_W-1:0]           ram_wdata_o,
    input  logic [DATA_W-1:0]           ram_rdata_i,

    // Storage reader
    output logic                        rd_start_o,
    output logic [23:0]                 rd_addr_o,
    input  logic                        rd_done_i,
    input  logic [DATA_W-1:0]           rd_data_i
);

    localparam int unsigned RAM_AW = $clog2(SRAM_WORDS);

    route_state_t state, next_state, decode_state;

    logic                accept;
    logic                start_q;
    logic                done_q;

    // Captured request
    logic [ADDR_W-1:0]   req_addr;
    logic                req_we;
    logic [DATA_W/8-1:0] req_be;
    logic [DATA_W-1:0]   req_wdata;

    logic [ADDR_W-1:0]   gpio_off;
    logic [ADDR_W-1:0]   sram_off;
    logic [ADDR_W-1:0]   storage_off;

    assign ready_o = (state == idle);
    assign accept  = req_i && ready_o;

    // Address decode of the incoming request
    always_comb begin
        if (addr_i <= RESERVED_LIMIT_LO) begin
            decode_state = error_resp;
        end else if (addr_i >= GPIO_DIR_BASE && addr_i < GPIO_VAL_BASE + GPIO_PINS) begin
            decode_state = gpio_access;
        end else if (addr_i == TIMER_ADDR) begin
            decode_state = timer_access;
        end else if (addr_i >= SRAM_BASE && addr_i <= SRAM_LIMIT &&
                     (addr_i - SRAM_BASE) < ADDR_W'(4 * SRAM_WORDS)) begin
            decode_state = sram_wait;
        end else if (addr_i >= STORAGE_BASE && !we_i) begin
            // Storage is read-only
            decode_state = storage_wait;
        end else begin
            decode_state = error_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= idle;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state   <= next_state;
            start_q <= accept && (decode_state == storage_wait);
            done_q  <= rd_done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr_i;
            req_we    <= we_i;
            req_be    <= be_i;
            req_wdata <= wdata_i;
        end
    end

    // Target-side fields from the held request
    assign gpio_is_dir_o = (req_addr < GPIO_VAL_BASE);
    assign gpio_off      = req_addr - (gpio_is_dir_o ? GPIO_DIR_BASE : GPIO_VAL_BASE);
    assign gpio_idx_o    = gpio_off[3:0];
    assign gpio_we_o     = req_we;
    assign gpio_wdata_o  = req_wdata;

    assign timer_load_val_o = req_wdata;

    assign sram_off        = req_addr - SRAM_BASE;
    assign ram_word_addr_o = sram_off[RAM_AW+1:2];
    assign ram_we_o        = req_we;
    assign ram_be_o        = req_be;
    assign ram_wdata_o     = req_wdata;

    assign storage_off = req_addr - STORAGE_BASE;
    assign rd_addr_o   = storage_off[23:0];
    assign rd_start_o  = start_q;

    // Strobes and response
    always_comb begin
        next_state   = state;
        rvalid_o     = 1'b0;
        err_o        = 1'b0;
        rdata_o      = '0;
        gpio_sel_o   = 1'b0;
        timer_load_o = 1'b0;
        ram_en_o     = 1'b0;

        case (state)
            idle: begin
                if (req_i) begin
                    next_state = decode_state;
                end
            end
            gpio_access: begin
                gpio_sel_o = 1'b1;
                err_o      = gpio_fault_i;
                rvalid_o   = !gpio_fault_i;
                if (!req_we && !gpio_fault_i) begin
                    rdata_o = gpio_rdata_i;
                end
                next_state = idle;
            end
            timer_access: begin
                // A write loads the counter, a read reports whether it runs
                timer_load_o = req_we;
                rvalid_o     = 1'b1;
                if (!req_we) begin
                    rdata_o = {{(DATA_W-1){1'b0}}, timer_running_i};
                end
                next_state = idle;
            end
            sram_wait: begin
                ram_en_o   = 1'b1;
                next_state = sram_done;
            end
            sram_done: begin
                rvalid_o = 1'b1;
                if (!req_we) begin
                    rdata_o = ram_rdata_i;
                end
                next_state = idle;
            end
            storage_wait: begin
                // Reader holds its data word after done
                if (done_q) begin
                    rvalid_o   = 1'b1;
                    rdata_o    = rd_data_i;
                    next_state = idle;
                end
            end
            error_resp: begin
                err_o      = 1'b1;
                next_state = idle;
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    // One response kind per request
    a_single_resp: assert property (@(posedge clk) disable iff (!rst)
        !(rvalid_o && err_o));

endmodule

// ==== verilog/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs import mem_map_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sel_i,
    input  logic                 we_i,
    input  logic [3:0]           idx_i,
    input  logic                 is_dir_i,
    input  logic [DATA_W-1:0]    wdata_i,
    input  logic [GPIO_PINS-1:0] gpio_i,
    output logic [DATA_W-1:0]    rdata_o,
    output logic                 fault_o,
    output logic [GPIO_PINS-1:0] gpio_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o
);

    // Direction 1 means input, 0 means output
    logic [GPIO_PINS-1:0] dir_q;
    logic [GPIO_PINS-1:0] val_q;

    assign gpio_oe_o = ~dir_q;
    assign gpio_o    = val_q;

    // Value writes need an output pin, value reads need an input pin
    assign fault_o = sel_i && !is_dir_i && (we_i ? dir_q[idx_i] : !dir_q[idx_i]);

    always_comb begin
        rdata_o = '0;
        if (is_dir_i) begin
            rdata_o[0] = dir_q[idx_i];
        end else begin
            rdata_o[0] = gpio_i[idx_i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dir_q <= '1;
            val_q <= '0;
        end else if (sel_i && we_i && !fault_o) begin
            if (is_dir_i) begin
                dir_q[idx_i] <= wdata_i[0];
            end else begin
                val_q[idx_i] <= wdata_i[0];
            end
        end
    end

    a_fault_no_write: assert property (@(posedge clk) disable iff (!rst)
        fault_o |=> $stable(val_q));

endmodule

// ==== verilog/countdown_timer.sv ====
`timescale 1ns/1ps

module countdown_timer #(
    parameter int unsigned TIMER_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_i,
    input  logic [TIMER_W-1:0] load_val_i,
    output logic               running_o
);

    logic [TIMER_W-1:0] count_q;

    // Counts down once per cycle and parks at zero
    always_ff @(posedge clk) begin
        if (!rst) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= load_val_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign running_o = (count_q != '0);

endmodule

// ==== verilog/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram import mem_map_pkg::*; #(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic                          clk,
    input  logic                          en_i,
    input  logic                          we_i,
    input  logic [DATA_W/8-1:0]           be_i,
    input  logic [$clog2(SRAM_WORDS)-1:0] word_addr_i,
    input  logic [DATA_W-1:0]             wdata_i,
    output logic [DATA_W-1:0]             rdata_o
);

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [DATA_W-1:0] rdata_q;

    always_ff @(posedge clk) begin
        if (en_i) begin
            // Byte lanes written only where enabled
            if (we_i) begin
                for (int b = 0; b < DATA_W/8; b++) begin
                    if (be_i[b]) begin
                        mem[word_addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            rdata_q <= mem[word_addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== verilog/spi_storage_reader.sv ====
`timescale 1ns/1ps

module spi_storage_reader import mem_map_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic [23:0]       addr_i,
    input  logic              miso_i,
    output logic              done_o,
    output logic [DATA_W-1:0] data_o,
    output logic              cs_n_o,
    output logic              sck_o,
    output logic              mosi_o
);

    typedef enum logic [1:0] {
        s_idle,
        s_xfer,
        s_done
    } spi_state_t;

    spi_state_t state;

    logic              sck_q;
    logic              cs_n_q;
    logic [5:0]        bit_cnt;
    logic [31:0]       tx_sr;
    logic [31:0]       rx_sr;
    logic [DATA_W-1:0] data_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= s_idle;
            sck_q   <= 1'b0;
            cs_n_q  <= 1'b1;
            bit_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    // Start requests while busy are dropped
                    if (start_i) begin
                        state   <= s_xfer;
                        cs_n_q  <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                s_xfer: begin
                    sck_q <= !sck_q;
                    if (sck_q) begin
                        // Falling edge ends a bit time
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 6'd63) begin
                            state  <= s_done;
                            cs_n_q <= 1'b1;
                        end
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // Shift registers carry payload only
    always_ff @(posedge clk) begin
        if (state == s_idle && start_i) begin
            tx_sr <= {SPI_READ_CMD, addr_i};
        end else if (state == s_xfer) begin
            if (!sck_q && bit_cnt >= 6'd32) begin
                // Sample on the rising edge, bytes arrive MSB first
                rx_sr <= {rx_sr[30:0], miso_i};
            end
            if (sck_q) begin
                tx_sr <= {tx_sr[30:0], 1'b0};
                if (bit_cnt == 6'd63) begin
                    // First byte received goes to the low lane
                    data_q <= {rx_sr[7:0], rx_sr[15:8], rx_sr[23:16], rx_sr[31:24]};
                end
            end
        end
    end

    assign done_o = (state == s_done);
    assign data_o = data_q;
    assign cs_n_o = cs_n_q;
    assign sck_o  = sck_q;
    assign mosi_o = tx_sr[31];

    a_cs_in_xfer: assert property (@(posedge clk) disable iff (!rst)
        !cs_n_o |-> (state == s_xfer));

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import mem_map_pkg::*; #(
    parameter int unsigned SRAM_WORDS = 1024,
    parameter int unsigned TIMER_W    = 32
) (
    input  logic                 clk,
    input  logic                 rst,

    // Core data bus
    input  logic                 req_i,
    input  logic [ADDR_W-1:0]    addr_i,
    input  logic                 we_i,
    input  logic [DATA_W/8-1:0]  be_i,
    input  logic [DATA_W-1:0]    wdata_i,
    output logic                 ready_o,
    output logic                 rvalid_o,
    output logic                 err_o,
    output logic [DATA_W-1:0]    rdata_o,

    // GPIO pins
    input  logic [GPIO_PINS-1:0] gpio_i,
    output logic [GPIO_PINS-1:0] gpio_o,
    output logic [GPIO_PINS-1:0] gpio_oe_o,

    // Storage flash
    input  logic                 spi_miso_i,
    output logic                 spi_cs_n_o,
    output logic                 spi_sck_o,
    output logic                 spi_mosi_o
);

    logic                          gpio_sel;
    logic                          gpio_we;
    logic [3:0]                    gpio_idx;
    logic                          gpio_is_dir;
    logic [DATA_W-1:0]             gpio_wdata;
    logic [DATA_W-1:0]             gpio_rdata;
    logic                          gpio_fault;
    logic                          timer_load;
    logic [DATA_W-1:0]             timer_load_val;
    logic                          timer_running;
    logic                          ram_en;
    logic                          ram_we;
    logic [DATA_W/8-1:0]           ram_be;
    logic [$clog2(SRAM_WORDS)-1:0] ram_word_addr;
    logic [DATA_W-1:0]             ram_wdata;
    logic [DATA_W-1:0]             ram_rdata;
    logic                          rd_start;
    logic [23:0]                   rd_addr;
    logic                          rd_done;
    logic [DATA_W-1:0]             rd_data;

    mem_router #(.SRAM_WORDS(SRAM_WORDS)) u_router (
        .clk(clk), .rst(rst),
        .req_i(req_i), .addr_i(addr_i), .we_i(we_i), .be_i(be_i), .wdata_i(wdata_i),
        .ready_o(ready_o), .rvalid_o(rvalid_o), .err_o(err_o), .rdata_o(rdata_o),
        .gpio_sel_o(gpio_sel), .gpio_we_o(gpio_we), .gpio_idx_o(gpio_idx),
        .gpio_is_dir_o(gpio_is_dir), .gpio_wdata_o(gpio_wdata),
        .gpio_rdata_i(gpio_rdata), .gpio_fault_i(gpio_fault),
        .timer_load_o(timer_load), .timer_load_val_o(timer_load_val),
        .timer_running_i(timer_running),
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_be_o(ram_be),
        .ram_word_addr_o(ram_word_addr), .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
        .rd_start_o(rd_start), .rd_addr_o(rd_addr), .rd_done_i(rd_done), .rd_data_i(rd_data)
    );

    gpio_regs u_gpio (
        .clk(clk), .rst(rst),
        .sel_i(gpio_sel), .we_i(gpio_we), .idx_i(gpio_idx), .is_dir_i(gpio_is_dir),
        .wdata_i(gpio_wdata), .gpio_i(gpio_i),
        .rdata_o(gpio_rdata), .fault_o(gpio_fault), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o)
    );

    // Counter takes the low TIMER_W bits of the written word
    countdown_timer #(.TIMER_W(TIMER_W)) u_timer (
        .clk(clk), .rst(rst),
        .load_i(timer_load), .load_val_i(timer_load_val[TIMER_W-1:0]),
        .running_o(timer_running)
    );

    scratch_ram #(.SRAM_WORDS(SRAM_WORDS)) u_ram (
        .clk(clk),
        .en_i(ram_en), .we_i(ram_we), .be_i(ram_be), .word_addr_i(ram_word_addr),
        .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

    spi_storage_reader u_storage (
        .clk(clk), .rst(rst),
        .start_i(rd_start), .addr_i(rd_addr), .miso_i(spi_miso_i),
        .done_o(rd_done), .data_o(rd_data),
        .cs_n_o(spi_cs_n_o), .sck_o(spi_sck_o), .mosi_o(spi_mosi_o)
    );

endmodule

// ==== verification/spi_flash_model.sv ====
`timescale 1ns/1ps

module spi_flash_model (
    input  logic cs_n_i,
    input  logic sck_i,
    input  logic mosi_i,
    output logic miso_o
);

    logic [31:0] cmd_sr;
    logic [7:0]  pat_byte;
    logic        miso_q = 1'b0;
    int          bit_cnt;
    int          k;

    // Opcode and 24-bit address shift in on rising SCK
    always @(negedge cs_n_i or posedge sck_i) begin
        if (!sck_i) begin
            bit_cnt <= 0;
        end else if (!cs_n_i) begin
            if (bit_cnt < 32) begin
                cmd_sr <= {cmd_sr[30:0], mosi_i};
            end
            bit_cnt <= bit_cnt + 1;
        end
    end

    // Data bits change on falling SCK, MSB of each byte first
    always @(negedge sck_i) begin
        if (!cs_n_i && bit_cnt >= 32 && bit_cnt < 64) begin
            k = bit_cnt - 32;
            // Byte at address a is the low byte of a xor 0x5A
            pat_byte = (cmd_sr[7:0] + 8'(k / 8)) ^ 8'h5A;
            // Anything but the read opcode gets zeros back
            if (cmd_sr[31:24] != 8'h03) begin
                pat_byte = 8'h00;
            end
            miso_q <= pat_byte[7 - (k % 8)];
        end
    end

    assign miso_o = miso_q;

endmodule

// ==== verification/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys import mem_map_pkg::*; ;

    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        ready;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
    logic [9:0]  gpio_in;
    logic [9:0]  gpio_out;
    logic [9:0]  gpio_oe;
    logic        miso;
    logic        cs_n;
    logic        sck;
    logic        mosi;

    // Shadow state for the expected responses
    logic [31:0] shadow_ram [1024];
    logic [9:0]  shadow_dir;
    logic [9:0]  shadow_val;
    logic        timer_exp;
    logic [31:0] lfsr_q;
    logic [32:0] exp_q [$];
    int          issued;
    int          resp_count;
    int          cycles;
    int          error_count;
    logic        busy;

    mem_subsys_top #(.SRAM_WORDS(1024), .TIMER_W(32)) dut (
        .clk(clk), .rst(rst),
        .req_i(req), .addr_i(addr), .we_i(we), .be_i(be), .wdata_i(wdata),
        .ready_o(ready), .rvalid_o(rvalid), .err_o(err), .rdata_o(rdata),
        .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe),
        .spi_miso_i(miso), .spi_cs_n_o(cs_n), .spi_sck_o(sck), .spi_mosi_o(mosi)
    );

    spi_flash_model u_flash (.cs_n_i(cs_n), .sck_i(sck), .mosi_i(mosi), .miso_o(miso));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[31]};
        end
        return r;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [31:0] a);
        return a[7:0] ^ 8'h5A;
    endfunction

    // Returns {err, rdata} for one access
    function automatic logic [32:0] expect_resp(input logic [31:0] a, input logic w);
        int          idx;
        logic [31:0] off;
        idx = 0;
        off = a - STORAGE_BASE;
        if (a <= RESERVED_LIMIT_LO) begin
            return {1'b1, 32'h0};
        end else if (a >= GPIO_DIR_BASE && a < GPIO_VAL_BASE) begin
            idx = int'(a - GPIO_DIR_BASE);
            return w ? 33'h0 : {1'b0, 31'h0, shadow_dir[idx]};
        end else if (a >= GPIO_VAL_BASE && a < TIMER_ADDR) begin
            idx = int'(a - GPIO_VAL_BASE);
            if (w) begin
                return {shadow_dir[idx], 32'h0};
            end else if (!shadow_dir[idx]) begin
                return {1'b1, 32'h0};
            end
            return {1'b0, 31'h0, gpio_in[idx]};
        end else if (a == TIMER_ADDR) begin
            return w ? 33'h0 : {1'b0, 31'h0, timer_exp};
        end else if (a >= SRAM_BASE && a <= SRAM_LIMIT) begin
            return w ? 33'h0 : {1'b0, shadow_ram[a[11:2]]};
        end else if (a >= STORAGE_BASE && !w) begin
            return {1'b0, flash_byte(off + 3), flash_byte(off + 2),
                    flash_byte(off + 1), flash_byte(off)};
        end
        return {1'b1, 32'h0};
    endfunction

    task automatic report_failure(input string why);
        $display("%0t ns: %s", $time, why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Drives a request, records the expectation and waits for acceptance
    task automatic issue(input logic [31:0] a, input logic w, input logic [3:0] b,
                         input logic [31:0] d);
        int idx;
        @(negedge clk);
        req   = 1'b1;
        addr  = a;
        we    = w;
        be    = b;
        wdata = d;
        exp_q.push_back(expect_resp(a, w));
        issued++;
        if (w && a >= GPIO_DIR_BASE && a < GPIO_VAL_BASE) begin
            idx = int'(a - GPIO_DIR_BASE);
            shadow_dir[idx] = d[0];
        end else if (w && a >= GPIO_VAL_BASE && a < TIMER_ADDR) begin
            idx = int'(a - GPIO_VAL_BASE);
            if (!shadow_dir[idx]) begin
                shadow_val[idx] = d[0];
            end
        end else if (w && a >= SRAM_BASE && a <= SRAM_LIMIT) begin
            for (int i = 0; i < 4; i++) begin
                if (b[i]) begin
                    shadow_ram[a[11:2]][i*8 +: 8] = d[i*8 +: 8];
                end
            end
        end
        do @(posedge clk); while (!ready);
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic access(input logic [31:0] a, input logic w, input logic [3:0] b,
                          input logic [31:0] d);
        issue(a, w, b, d);
        wait (resp_count == issued);
    endtask

    // Compares every response with the oldest expectation
    always @(posedge clk) begin
        logic [32:0] e;
        if (rst) begin
            if (rvalid && err) begin
                report_failure("rvalid and err were high in the same cycle");
            end
            if (busy && ready) begin
                report_failure("ready rose before the response of the accepted request");
            end
            if (rvalid || err) begin
                if (exp_q.size() == 0) begin
                    report_failure("a response came without an outstanding request");
                end
                e = exp_q.pop_front();
                check_value({31'h0, err}, {31'h0, e[32]}, "err");
                if (rvalid) begin
                    check_value(rdata, e[31:0], "rdata");
                end
                busy = 1'b0;
                resp_count++;
            end
            if (req && ready) begin
                busy = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure("timeout, the tests did not finish in time");
        end
    end

    initial begin
        logic [31:0] a;
        rst = 1'b0;
        req = 1'b0;
        addr = '0;
        we = 1'b0;
        be = '0;
        wdata = '0;
        gpio_in = '0;
        lfsr_q = 32'h7d4d;
        shadow_dir = '1;
        shadow_val = '0;
        timer_exp = 1'b0;
        issued = 0;
        resp_count = 0;
        cycles = 0;
        error_count = 0;
        busy = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_value({31'h0, ready}, 32'h1, "ready after reset");
        check_value({30'h0, rvalid, err}, 32'h0, "responses after reset");
        check_value({22'h0, gpio_oe}, 32'h0, "gpio_oe after reset");
        check_value({30'h0, cs_n, sck}, 32'h2, "cs_n and sck after reset");

        // Reserved ranges and storage writes
        access(32'h0, 1'b0, 4'hF, 32'h0);
        access(32'h100, 1'b0, 4'hF, 32'h0);
        access(32'h116, 1'b1, 4'hF, 32'h1234);
        access(32'hFFF, 1'b0, 4'hF, 32'h0);
        access(STORAGE_BASE, 1'b1, 4'hF, 32'h55);
        access(STORAGE_BASE + rand_bits(20), 1'b1, 4'hF, 32'h66);

        // Scratch RAM over a 32-word window
        for (int w = 0; w < 32; w++) begin
            access(SRAM_BASE + 32'(w * 4), 1'b1, 4'hF, rand_bits(32));
        end
        for (int n = 0; n < 200; n++) begin
            a = SRAM_BASE + (rand_bits(5) << 2);
            access(a, 1'b1, 4'(rand_bits(4)), rand_bits(32));
            access(SRAM_BASE + (rand_bits(5) << 2), 1'b0, 4'hF, 32'h0);
        end

        // GPIO, pins 0 to 4 become outputs
        gpio_in = 10'(rand_bits(10));
        for (int p = 0; p < 5; p++) begin
            access(GPIO_DIR_BASE + 32'(p), 1'b1, 4'hF, 32'h0);
        end
        @(negedge clk);
        check_value({22'h0, gpio_oe}, {22'h0, ~shadow_dir}, "gpio_oe");
        for (int p = 0; p < 5; p++) begin
            access(GPIO_VAL_BASE + 32'(p), 1'b1, 4'hF, rand_bits(1));
        end
        @(negedge clk);
        check_value({22'h0, gpio_out}, {22'h0, shadow_val}, "gpio_o");
        for (int p = 0; p < 10; p++) begin
            access(GPIO_DIR_BASE + 32'(p), 1'b0, 4'hF, 32'h0);
        end
        for (int p = 5; p < 10; p++) begin
            access(GPIO_VAL_BASE + 32'(p), 1'b0, 4'hF, 32'h0);
        end
        access(GPIO_VAL_BASE + 32'd7, 1'b1, 4'hF, 32'h1);
        access(GPIO_VAL_BASE + 32'd2, 1'b0, 4'hF, 32'h0);
        @(negedge clk);
        check_value({22'h0, gpio_out}, {22'h0, shadow_val}, "gpio_o after faults");

        // Timer loaded with 40
        access(TIMER_ADDR, 1'b1, 4'hF, 32'd40);
        timer_exp = 1'b1;
        access(TIMER_ADDR, 1'b0, 4'hF, 32'h0);
        repeat (45) @(posedge clk);
        timer_exp = 1'b0;
        access(TIMER_ADDR, 1'b0, 4'hF, 32'h0);

        // Storage reads
        for (int n = 0; n < 10; n++) begin
            access(STORAGE_BASE + rand_bits(20), 1'b0, 4'hF, 32'h0);
        end

        // A RAM read held while a storage read is in flight
        issue(STORAGE_BASE + rand_bits(20), 1'b0, 4'hF, 32'h0);
        issue(SRAM_BASE + 32'd12, 1'b0, 4'hF, 32'h0);
        wait (resp_count == issued);

        @(negedge clk);
        if (error_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== build.f ====
verilog/mem_map_pkg.sv
verilog/mem_router.sv
verilog/gpio_regs.sv
verilog/countdown_timer.sv
verilog/scratch_ram.sv
verilog/spi_storage_reader.sv
verilog/mem_subsys_top.sv
verification/spi_flash_model.sv
verification/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_subsys
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
